// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the matrix power testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing -f sim.f --top-module matrix_power_tb -Mdir obj_dir
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/Vmatrix_power_tb
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation failed with status $sim_status"
  exit "$sim_status"
fi

exit 0

// ==== sim.f ====
+incdir+testbench
verilog/matrix_power_pkg.sv
verilog/element_dispatcher.sv
verilog/power_lane.sv
verilog/result_collector.sv
verilog/matrix_power_top.sv
testbench/matrix_power_tb.sv

// ==== testbench/matrix_power_checks.svh ====
// Include inside the testbench module after abort_run; expects matrix_power_pkg imported there
`ifndef MATRIX_POWER_CHECKS_SVH
`define MATRIX_POWER_CHECKS_SVH

////////////////////////////////////////
// Stimulus and reference model
////////////////////////////////////////

// 32-bit LCG step with full period modulo 2**32
function automatic logic [31:0] lcg_step(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Square and multiply over the exponent bits with wrap modulo 2**ELEM_WIDTH
function automatic elem_t power_ref(input elem_t base, input logic [EXP_WIDTH-1:0] exponent);
  elem_t result;
  elem_t square;
  result = elem_t'(1);
  square = base;
  for (int b = 0; b < EXP_WIDTH; b++) begin
    if (exponent[b]) begin
      result = result * square;
    end
    square = square * square;
  end
  return result;
endfunction

////////////////////////////////////////
// Typed compares
////////////////////////////////////////

// Element results
task automatic compare_elem(input string name, input elem_t expected, input elem_t actual);
  if (actual !== expected) begin
    abort_run($sformatf("Mismatch at %0d ns: %s expected 0x%08h, got 0x%08h",
                        $time, name, expected, actual));
  end
endtask

// Job activity flag
task automatic compare_busy(input logic expected, input logic actual);
  if (actual !== expected) begin
    abort_run($sformatf("Mismatch at %0d ns: busy expected %b, got %b",
                        $time, expected, actual));
  end
endtask

// Handshake levels
task automatic compare_level(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    abort_run($sformatf("Mismatch at %0d ns: %s expected %b, got %b",
                        $time, name, expected, actual));
  end
endtask

`endif

// ==== testbench/matrix_power_tb.sv ====
// Directed testbench at the default LANES; inputs change on falling edges, needs timing support
`timescale 1ns/1ps

module matrix_power_tb
  import matrix_power_pkg::*;
();

  // Element count over all tests below
  localparam int TOTAL_ELEMS     = 58;
  localparam int MAX_ACK_DELAY   = 12;
  localparam int WATCHDOG_CYCLES = TOTAL_ELEMS * (31 + MAX_ACK_DELAY + 10) + 400;

  logic  CLK;
  logic  RST;
  logic  job_req;
  job_t  job;
  logic  job_ack;
  logic  in_req;
  elem_t in_data;
  logic  in_ack;
  logic  out_req;
  elem_t out_data;
  logic  out_ack;
  logic  busy;

  // Expected results, row-major
  elem_t       exp_queue[$];
  // Separate streams for data and out_ack delays
  logic [31:0] data_seed;
  logic [31:0] delay_seed;
  int          ack_delay_min;
  int          ack_delay_max;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  `include "matrix_power_checks.svh"

  matrix_power_top matrix_power_top_inst (
    .CLK     (CLK),
    .RST     (RST),
    .job_req (job_req),
    .job     (job),
    .job_ack (job_ack),
    .in_req  (in_req),
    .in_data (in_data),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out_data(out_data),
    .out_ack (out_ack),
    .busy    (busy)
  );

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    abort_run($sformatf("Timeout: tests did not finish within %0d clock cycles",
                        WATCHDOG_CYCLES));
  end

  function automatic elem_t next_data();
    data_seed = lcg_step(data_seed);
    return data_seed;
  endfunction

  // Uniform-ish 0..limit from the upper LCG bits
  function automatic int next_delay(input int limit);
    delay_seed = lcg_step(delay_seed);
    return int'(delay_seed[27:16]) % (limit + 1);
  endfunction

  ////////////////////////////////////////
  // Four-phase drivers
  ////////////////////////////////////////

  task automatic send_job(input logic [DIM_WIDTH-1:0] rows, input logic [DIM_WIDTH-1:0] cols,
                          input logic [EXP_WIDTH-1:0] exponent);
    @(negedge CLK);
    job.rows     = rows;
    job.cols     = cols;
    job.exponent = exponent;
    job_req      = 1'b1;
    do begin
      @(negedge CLK);
    end while (!job_ack);
    job_req = 1'b0;
    do begin
      @(negedge CLK);
    end while (job_ack);
    // Collector already armed
    compare_busy(1'b1, busy);
  endtask

  // Reports falling edges spent waiting for in_ack
  task automatic send_elem(input elem_t value, output int waited);
    @(negedge CLK);
    in_data = value;
    in_req  = 1'b1;
    waited  = 0;
    do begin
      @(negedge CLK);
      waited++;
    end while (!in_ack);
    in_req = 1'b0;
    do begin
      @(negedge CLK);
    end while (in_ack);
  endtask

  // Output side, runs for the whole simulation
  task automatic respond_outputs();
    int delay;
    forever begin
      @(negedge CLK);
      if (out_req && !out_ack) begin
        if (exp_queue.size() == 0) begin
          abort_run("Output result appeared with no input pending");
        end
        compare_elem("out_data", exp_queue.pop_front(), out_data);
        delay = ack_delay_min + next_delay(ack_delay_max - ack_delay_min);
        repeat (delay) @(negedge CLK);
        out_ack = 1'b1;
      end else if (!out_req && out_ack) begin
        // busy must outlast the return to zero
        compare_busy(1'b1, busy);
        out_ack = 1'b0;
      end
    end
  endtask

  task automatic wait_job_done();
    do begin
      @(negedge CLK);
    end while (busy);
    if (exp_queue.size() != 0) begin
      abort_run($sformatf("busy fell with %0d results still missing", exp_queue.size()));
    end
    compare_level("out_req", 1'b0, out_req);
    compare_level("job_ack", 1'b0, job_ack);
    compare_level("in_ack", 1'b0, in_ack);
  endtask

  task automatic run_job(input logic [DIM_WIDTH-1:0] rows, input logic [DIM_WIDTH-1:0] cols,
                         input logic [EXP_WIDTH-1:0] exponent, input logic random_data,
                         input elem_t first_value, output int max_wait);
    int    count;
    int    waited;
    elem_t value;
    count    = int'(rows) * int'(cols);
    max_wait = 0;
    send_job(rows, cols, exponent);
    for (int n = 0; n < count; n++) begin
      value = random_data ? next_data() : first_value + elem_t'(n);
      exp_queue.push_back(power_ref(value, exponent));
      send_elem(value, waited);
      if (waited > max_wait) begin
        max_wait = waited;
      end
    end
    wait_job_done();
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic check_reset_state();
    compare_level("job_ack", 1'b0, job_ack);
    compare_level("in_ack", 1'b0, in_ack);
    compare_level("out_req", 1'b0, out_req);
    compare_busy(1'b0, busy);
  endtask

  task automatic test_single_element();
    int max_wait;
    ack_delay_min = 0;
    ack_delay_max = 0;
    run_job(8'd1, 8'd1, 5'd3, 1'b0, 32'd7, max_wait);
  endtask

  task automatic test_exponent_edges();
    int max_wait;
    ack_delay_min = 0;
    ack_delay_max = 2;
    // All ones expected
    run_job(8'd2, 8'd3, 5'd0, 1'b1, '0, max_wait);
    // Identity
    run_job(8'd2, 8'd2, 5'd1, 1'b1, '0, max_wait);
  endtask

  task automatic test_random_matrix();
    int                   max_wait;
    logic [EXP_WIDTH-1:0] exponent;
    ack_delay_min = 0;
    ack_delay_max = 5;
    // At least squared, so large operands wrap
    exponent = EXP_WIDTH'(2 + int'(next_data() % 30));
    run_job(8'd4, 8'd5, exponent, 1'b1, '0, max_wait);
  endtask

  task automatic test_back_pressure();
    int max_wait;
    ack_delay_min = 4;
    ack_delay_max = MAX_ACK_DELAY;
    run_job(8'd3, 8'd7, 5'd7, 1'b1, '0, max_wait);
    // Unstalled accept takes 3 falling edges
    if (max_wait <= 5) begin
      abort_run("in_ack never stalled while output results were held back");
    end
  endtask

  task automatic test_back_to_back();
    int max_wait;
    ack_delay_min = 0;
    ack_delay_max = 3;
    run_job(8'd3, 8'd2, 5'd13, 1'b1, '0, max_wait);
  endtask

  initial begin
    RST           = 1'b1;
    job_req       = 1'b0;
    job           = '0;
    in_req        = 1'b0;
    in_data       = '0;
    out_ack       = 1'b0;
    data_seed     = 32'd57610;
    delay_seed    = lcg_step(32'd57610);
    ack_delay_min = 0;
    ack_delay_max = 0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    fork
      respond_outputs();
    join_none
    check_reset_state();
    test_single_element();
    test_exponent_edges();
    test_random_matrix();
    test_back_pressure();
    test_back_to_back();
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== verilog/element_dispatcher.sv ====
// Accepts one job at a time and walks its elements row-major; a new job waits until idle
`timescale 1ns/1ps

module element_dispatcher
  import matrix_power_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic               CLK,
  input  logic               RST,
  input  logic               job_req,
  input  job_t               job,
  output logic               job_ack,
  input  logic               in_req,
  input  elem_t              in_data,
  output logic               in_ack,
  output logic               job_start,
  output job_t               job_info,
  output logic [LANES-1:0]   task_req,
  output lane_task_t         task_data,
  input  logic [LANES-1:0]   task_ack,
  input  logic [LANES-1:0]   lane_idle
);

  // Pointer needs at least one bit even for a single lane
  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  dispatch_state_e      state;
  job_t                 job_reg;
  logic [DIM_WIDTH-1:0] i_idx;
  logic [DIM_WIDTH-1:0] j_idx;
  logic [PTR_W-1:0]     ptr;
  logic                 job_accept;
  logic                 elem_accept;
  logic                 last_elem;

  // New job only from idle
  assign job_accept  = (state == DSP_IDLE) && job_req;
  // Element taken once the target lane is free and the last input handshake is closed
  assign elem_accept = (state == DSP_WAIT_ELEM) && in_req && !in_ack &&
                       !task_ack[ptr] && lane_idle[ptr];
  assign last_elem   = (i_idx == job_reg.rows - 1'b1) && (j_idx == job_reg.cols - 1'b1);
  assign job_info    = job_reg;

  ////////////////////////////////////////
  // Payload capture
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (job_accept) begin
      job_reg <= job;
    end
    if (elem_accept) begin
      task_data.operand  <= in_data;
      task_data.exponent <= job_reg.exponent;
    end
  end

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= DSP_IDLE;
      job_ack   <= 1'b0;
      in_ack    <= 1'b0;
      job_start <= 1'b0;
      task_req  <= '0;
      i_idx     <= '0;
      j_idx     <= '0;
      ptr       <= '0;
    end else begin
      job_start <= 1'b0;
      // Input return to zero, in any state
      if (in_ack && !in_req) begin
        in_ack <= 1'b0;
      end
      case (state)
        DSP_IDLE: begin
          if (job_accept) begin
            job_ack   <= 1'b1;
            job_start <= 1'b1;
            i_idx     <= '0;
            j_idx     <= '0;
            ptr       <= '0;
            state     <= DSP_JOB_ACK;
          end
        end
        DSP_JOB_ACK: begin
          if (!job_req) begin
            job_ack <= 1'b0;
            state   <= DSP_WAIT_ELEM;
          end
        end
        DSP_WAIT_ELEM: begin
          if (elem_accept) begin
            in_ack        <= 1'b1;
            task_req[ptr] <= 1'b1;
            state         <= DSP_SEND;
          end
        end
        DSP_SEND: begin
          // Lane has latched the task
          if (task_ack[ptr]) begin
            task_req[ptr] <= 1'b0;
            state         <= DSP_RELEASE;
          end
        end
        DSP_RELEASE: begin
          if (!task_ack[ptr]) begin
            ptr <= (ptr == PTR_W'(LANES - 1)) ? '0 : ptr + 1'b1;
            // Row-major index walk
            if (j_idx == job_reg.cols - 1'b1) begin
              j_idx <= '0;
              i_idx <= i_idx + 1'b1;
            end else begin
              j_idx <= j_idx + 1'b1;
            end
            state <= last_elem ? DSP_IDLE : DSP_WAIT_ELEM;
          end
        end
        default: begin
          state <= DSP_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== verilog/matrix_power_pkg.sv ====
// Shared types for the power engine; elements are unsigned and results wrap modulo 2**ELEM_WIDTH
package matrix_power_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // One matrix element
  localparam int ELEM_WIDTH = 32;
  // Row or column count
  localparam int DIM_WIDTH  = 8;
  // Exponent, so at most 31 multiplies per element
  localparam int EXP_WIDTH  = 5;

  ////////////////////////////////////////
  // Data types
  ////////////////////////////////////////

  typedef logic [ELEM_WIDTH-1:0] elem_t;

  // Job descriptor, rows and cols at least 1
  typedef struct packed {
    logic [DIM_WIDTH-1:0] rows;
    logic [DIM_WIDTH-1:0] cols;
    logic [EXP_WIDTH-1:0] exponent;
  } job_t;

  // Work unit handed to one lane
  typedef struct packed {
    elem_t                operand;
    logic [EXP_WIDTH-1:0] exponent;
  } lane_task_t;

  ////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    LANE_IDLE,
    LANE_MULT,
    LANE_HOLD,
    LANE_RELEASE
  } lane_state_e;

  typedef enum logic [2:0] {
    DSP_IDLE,
    DSP_JOB_ACK,
    DSP_WAIT_ELEM,
    DSP_SEND,
    DSP_RELEASE
  } dispatch_state_e;

endpackage

// ==== verilog/matrix_power_top.sv ====
// Element-wise matrix power engine; start a new job only while busy is low
`timescale 1ns/1ps

module matrix_power_top
  import matrix_power_pkg::*;
#(
  // Lane count, 1 to 8
  parameter int LANES = 4
) (
  input  logic  CLK,
  input  logic  RST,
  input  logic  job_req,
  input  job_t  job,
  output logic  job_ack,
  input  logic  in_req,
  input  elem_t in_data,
  output logic  in_ack,
  output logic  out_req,
  output elem_t out_data,
  input  logic  out_ack,
  output logic  busy
);

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////

  logic              job_start;
  job_t              job_info;
  // Task links, payload shared by all lanes
  logic [LANES-1:0]  task_req;
  logic [LANES-1:0]  task_ack;
  lane_task_t        task_data;
  logic [LANES-1:0]  lane_idle;
  // Result links
  logic [LANES-1:0]  res_req;
  logic [LANES-1:0]  res_ack;
  elem_t [LANES-1:0] res_data;

  element_dispatcher #(
    .LANES(LANES)
  ) element_dispatcher_inst (
    .CLK      (CLK),
    .RST      (RST),
    .job_req  (job_req),
    .job      (job),
    .job_ack  (job_ack),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .job_start(job_start),
    .job_info (job_info),
    .task_req (task_req),
    .task_data(task_data),
    .task_ack (task_ack),
    .lane_idle(lane_idle)
  );

  // One power unit per lane
  for (genvar k = 0; k < LANES; k++) begin : gen_lane
    power_lane power_lane_inst (
      .CLK      (CLK),
      .RST      (RST),
      .task_req (task_req[k]),
      .task_data(task_data),
      .task_ack (task_ack[k]),
      .idle     (lane_idle[k]),
      .res_req  (res_req[k]),
      .res_data (res_data[k]),
      .res_ack  (res_ack[k])
    );
  end

  result_collector #(
    .LANES(LANES)
  ) result_collector_inst (
    .CLK      (CLK),
    .RST      (RST),
    .job_start(job_start),
    .job_info (job_info),
    .res_req  (res_req),
    .res_data (res_data),
    .res_ack  (res_ack),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack),
    .busy     (busy)
  );

endmodule

// ==== verilog/power_lane.sv ====
// Iterative power unit, one multiply per cycle; result is exponent+1 cycles after task accept
`timescale 1ns/1ps

module power_lane
  import matrix_power_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       task_req,
  input  lane_task_t task_data,
  output logic       task_ack,
  output logic       idle,
  output logic       res_req,
  output elem_t      res_data,
  input  logic       res_ack
);

  lane_state_e          state;
  logic [EXP_WIDTH-1:0] exp_cnt;
  elem_t                operand;
  logic                 task_accept;

  // Ignore a request whose ack has not yet returned low
  assign task_accept = (state == LANE_IDLE) && task_req && !task_ack;
  assign idle        = (state == LANE_IDLE);

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Accumulator doubles as the result register
  always_ff @(posedge CLK) begin
    if (task_accept) begin
      operand  <= task_data.operand;
      res_data <= elem_t'(1);
    end else if (state == LANE_MULT && exp_cnt != '0) begin
      // Low ELEM_WIDTH bits only
      res_data <= res_data * operand;
    end
  end

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= LANE_IDLE;
      exp_cnt  <= '0;
      task_ack <= 1'b0;
      res_req  <= 1'b0;
    end else begin
      // Task link return to zero
      if (task_ack && !task_req) begin
        task_ack <= 1'b0;
      end
      case (state)
        LANE_IDLE: begin
          if (task_accept) begin
            task_ack <= 1'b1;
            exp_cnt  <= task_data.exponent;
            state    <= LANE_MULT;
          end
        end
        LANE_MULT: begin
          // Count down remaining multiplies
          if (exp_cnt == '0) begin
            res_req <= 1'b1;
            state   <= LANE_HOLD;
          end else begin
            exp_cnt <= exp_cnt - 1'b1;
          end
        end
        LANE_HOLD: begin
          // Result held until the collector takes it
          if (res_ack) begin
            res_req <= 1'b0;
            state   <= LANE_RELEASE;
          end
        end
        LANE_RELEASE: begin
          if (!res_ack) begin
            state <= LANE_IDLE;
          end
        end
        default: begin
          state <= LANE_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== verilog/result_collector.sv ====
// Drains lanes strictly in round-robin order; job_start must not arrive while busy
`timescale 1ns/1ps

module result_collector
  import matrix_power_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  job_start,
  input  job_t                  job_info,
  input  logic [LANES-1:0]      res_req,
  input  elem_t [LANES-1:0]     res_data,
  output logic [LANES-1:0]      res_ack,
  output logic                  out_req,
  output elem_t                 out_data,
  input  logic                  out_ack,
  output logic                  busy
);

  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  // Local collector states
  typedef enum logic [1:0] {
    COL_IDLE,
    COL_WAIT,
    COL_OUT,
    COL_RELEASE
  } col_state_e;

  col_state_e             state;
  logic [PTR_W-1:0]       ptr;
  logic [2*DIM_WIDTH-1:0] remaining;

  ////////////////////////////////////////
  // Output data
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == COL_WAIT && res_req[ptr]) begin
      out_data <= res_data[ptr];
    end
  end

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= COL_IDLE;
      ptr       <= '0;
      remaining <= '0;
      res_ack   <= '0;
      out_req   <= 1'b0;
      busy      <= 1'b0;
    end else begin
      case (state)
        COL_IDLE: begin
          if (job_start) begin
            // Element count of the new job
            remaining <= (2*DIM_WIDTH)'(job_info.rows) * (2*DIM_WIDTH)'(job_info.cols);
            ptr       <= '0;
            busy      <= 1'b1;
            state     <= COL_WAIT;
          end
        end
        COL_WAIT: begin
          // Only the lane under the pointer is served
          if (res_req[ptr]) begin
            out_req <= 1'b1;
            state   <= COL_OUT;
          end
        end
        COL_OUT: begin
          if (out_ack) begin
            out_req      <= 1'b0;
            res_ack[ptr] <= 1'b1;
            state        <= COL_RELEASE;
          end
        end
        COL_RELEASE: begin
          // Both handshakes back to zero
          if (!res_req[ptr] && !out_ack) begin
            res_ack[ptr] <= 1'b0;
            remaining    <= remaining - 1'b1;
            ptr          <= (ptr == PTR_W'(LANES - 1)) ? '0 : ptr + 1'b1;
            if (remaining == 1) begin
              busy  <= 1'b0;
              state <= COL_IDLE;
            end else begin
              state <= COL_WAIT;
            end
          end
        end
        default: begin
          state <= COL_IDLE;
        end
      endcase
    end
  end

endmodule
